// File: verilog/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // major opcode, instruction bits 6..2
  typedef enum logic [4:0] {
    opc_load   = 5'b00000,
    opc_op_imm = 5'b00100,
    opc_auipc  = 5'b00101,
    opc_store  = 5'b01000,
    opc_op     = 5'b01100,
    opc_lui    = 5'b01101,
    opc_branch = 5'b11000,
    opc_jalr   = 5'b11001,
    opc_jal    = 5'b11011,
    opc_system = 5'b11100
  } opcode_t;

  typedef enum logic [2:0] {
    br_beq  = 3'b000,
    br_bne  = 3'b001,
    br_blt  = 3'b100,
    br_bge  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } branch_funct_t;

  // zicsr funct3, bit 2 selects the immediate form
  typedef enum logic [2:0] {
    csr_rw  = 3'b001,
    csr_rs  = 3'b010,
    csr_rc  = 3'b011,
    csr_rwi = 3'b101,
    csr_rsi = 3'b110,
    csr_rci = 3'b111
  } csr_funct_t;

  localparam logic [11:0] csr_mstatus = 12'h300;
  localparam logic [11:0] csr_mtvec   = 12'h305;
  localparam logic [11:0] csr_mepc    = 12'h341;
  localparam logic [11:0] csr_mcause  = 12'h342;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_t    opcode;
    logic [1:0] quadrant;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_t     opcode;
    logic [1:0]  quadrant;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    opcode_t    opcode;
    logic [1:0] quadrant;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_t    opcode;
    logic [1:0] quadrant;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    opcode_t     opcode;
    logic [1:0]  quadrant;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    opcode_t    opcode;
    logic [1:0] quadrant;
  } j_fmt_t;

  // one instruction word, viewed in each base format
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } inst_t;

endpackage

`default_nettype wire

// File: verilog/decode_pkg.sv
`default_nettype none

package decode_pkg;

  // same codes as funct3 of the register-register ALU ops
  typedef enum logic [2:0] {
    alu_add = 3'b000,
    alu_shl = 3'b001,
    alu_lts = 3'b010,
    alu_ltu = 3'b011,
    alu_xor = 3'b100,
    alu_shr = 3'b101,
    alu_or  = 3'b110,
    alu_and = 3'b111
  } alu_funct_t;

  typedef enum logic [2:0] {
    goto_none = 3'b000,
    goto_pc_c = 3'b001,
    goto_a_c  = 3'b010,
    goto_a    = 3'b011,
    // conditional on the ALU result
    goto_nz   = 3'b100,
    goto_z    = 3'b101
  } goto_t;

  typedef enum logic [1:0] {
    csrw_none   = 2'b00,
    csrw_alu    = 2'b01,
    csrw_val_b  = 2'b10,
    csrw_ebreak = 2'b11
  } csrw_t;

  typedef enum logic [1:0] {
    sel_a_zero = 2'd0,
    sel_a_rs1  = 2'd1,
    sel_a_csr  = 2'd2
  } sel_a_t;

  typedef enum logic [2:0] {
    sel_b_zero  = 3'd0,
    sel_b_imm_u = 3'd1,
    sel_b_four  = 3'd2,
    sel_b_rs2   = 3'd3,
    sel_b_imm_i = 3'd4,
    sel_b_imm_s = 3'd5,
    sel_b_imm_z = 3'd6,
    sel_b_pc    = 3'd7
  } sel_b_t;

  typedef enum logic [2:0] {
    sel_c_zero     = 3'd0,
    sel_c_imm_j    = 3'd1,
    sel_c_imm_i    = 3'd2,
    sel_c_imm_b    = 3'd3,
    sel_c_rs2      = 3'd4,
    sel_c_csr_addr = 3'd5
  } sel_c_t;

  typedef struct packed {
    // 1 selects pc instead of val_a as ALU operand
    logic       alu_src;
    alu_funct_t alu_funct;
    logic       alu_sw;
    // rd of zero means no register write
    logic [4:0] rd;
    // 1 writes val_a (old CSR value) to rd
    logic       rd_src;
    // {load, sign, size}, store is {0, 1, size}
    logic [3:0] ls;
    goto_t      goto;
    csrw_t      csrw;
  } ctrl_t;

  typedef struct packed {
    sel_a_t sel_a;
    sel_b_t sel_b;
    sel_c_t sel_c;
  } sel_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] val_a;
    logic [31:0] val_b;
    logic [31:0] val_c;
  } operands_t;

  typedef struct packed {
    logic        en;
    logic [4:0]  addr;
    logic [31:0] data;
  } gpr_wr_t;

  typedef struct packed {
    logic        en;
    logic [11:0] addr;
    logic [31:0] data;
  } csr_wr_t;

endpackage

`default_nettype wire

// File: verilog/gpr_file.sv
`default_nettype none

module gpr_file #(
  parameter int num_gpr = 32
) (
  input  logic                clock,
  input  logic                reset,
  input  logic [4:0]          raddr1,
  output logic [31:0]         rdata1,
  input  logic [4:0]          raddr2,
  output logic [31:0]         rdata2,
  input  decode_pkg::gpr_wr_t wr
);

  // x0 has no storage
  logic [31:0] regs [1:num_gpr-1];

  function automatic logic [31:0] read_reg(input logic [4:0] addr);
    if (addr == 5'd0 || addr >= num_gpr) begin
      return 32'd0;
    end
    return regs[addr];
  endfunction

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int k = 1; k < num_gpr; k++) begin
        regs[k] <= 32'd0;
      end
    end else if (wr.en && wr.addr != 5'd0 && wr.addr < num_gpr) begin
      regs[wr.addr] <= wr.data;
    end
  end

  always_comb begin
    rdata1 = read_reg(raddr1);
    rdata2 = read_reg(raddr2);
  end

endmodule

`default_nettype wire

// File: verilog/csr_file.sv
`default_nettype none

module csr_file (
  input  logic                clock,
  input  logic                reset,
  input  logic [11:0]         raddr,
  output logic [31:0]         rdata,
  input  decode_pkg::csr_wr_t wr
);

  logic [31:0] mstatus;
  logic [31:0] mtvec;
  logic [31:0] mepc;
  logic [31:0] mcause;

  always_ff @(posedge clock) begin
    if (reset) begin
      mstatus <= 32'd0;
      mtvec   <= 32'd0;
      mepc    <= 32'd0;
      mcause  <= 32'd0;
    end else if (wr.en) begin
      // writes to unimplemented addresses are dropped
      case (wr.addr)
        rv_isa_pkg::csr_mstatus: mstatus <= wr.data;
        rv_isa_pkg::csr_mtvec:   mtvec   <= wr.data;
        rv_isa_pkg::csr_mepc:    mepc    <= wr.data;
        rv_isa_pkg::csr_mcause:  mcause  <= wr.data;
        default: begin
        end
      endcase
    end
  end

  always_comb begin
    case (raddr)
      rv_isa_pkg::csr_mstatus: rdata = mstatus;
      rv_isa_pkg::csr_mtvec:   rdata = mtvec;
      rv_isa_pkg::csr_mepc:    rdata = mepc;
      rv_isa_pkg::csr_mcause:  rdata = mcause;
      default:                 rdata = 32'd0;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/decode_ctrl.sv
`default_nettype none

module decode_ctrl (
  input  logic                clock,
  input  logic                reset,
  input  logic                flush,
  input  logic                in_valid,
  output logic                in_ready,
  input  logic [31:0]         in_pc,
  input  rv_isa_pkg::inst_t   in_inst,
  output logic                out_valid,
  input  logic                out_ready,
  output rv_isa_pkg::inst_t   held_inst,
  output logic [31:0]         held_pc,
  output decode_pkg::ctrl_t   ctrl,
  output decode_pkg::sel_t    sel,
  output logic [4:0]          gpr_raddr1,
  output logic [4:0]          gpr_raddr2,
  output logic [11:0]         csr_raddr
);

  typedef enum logic {
    st_idle,
    st_hold
  } state_t;

  state_t                 state;
  state_t                 state_next;
  logic                   accept;
  rv_isa_pkg::opcode_t    opcode;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  logic [11:0]            funct12;
  logic                   zicsr;
  logic                   ebreak;
  decode_pkg::alu_funct_t branch_alu;
  decode_pkg::alu_funct_t csr_alu;

  assign in_ready  = (state == st_idle) || (out_ready || flush);
  assign out_valid = (state == st_hold) && !flush;
  assign accept    = in_valid && in_ready;

  always_comb begin
    state_next = state;
    if (accept) begin
      state_next = st_hold;
    end else if (state == st_hold && (out_ready || flush)) begin
      state_next = st_idle;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= st_idle;
      // nop: addi x0, x0, 0
      held_inst <= 32'h0000_0013;
    end else begin
      state <= state_next;
      if (accept) begin
        held_inst <= in_inst;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      held_pc <= in_pc;
    end
  end

  assign opcode  = held_inst.r.opcode;
  assign funct3  = held_inst.r.funct3;
  assign funct7  = held_inst.r.funct7;
  assign funct12 = held_inst.i.imm;

  // only the zicsr ops have a nonzero funct3 among SYSTEM
  assign zicsr  = |funct3;
  assign ebreak = funct12[1:0] == 2'b01;

  // mret returns through mepc, ecall enters through mtvec
  assign csr_raddr  = zicsr ? funct12 : (funct12[1] ? rv_isa_pkg::csr_mepc
                                                    : rv_isa_pkg::csr_mtvec);
  assign gpr_raddr1 = held_inst.r.rs1;
  // port 2 carries rs1 for zicsr so that val_b can take the rs2 path
  assign gpr_raddr2 = (opcode == rv_isa_pkg::opc_system) ? held_inst.r.rs1
                                                         : held_inst.r.rs2;

  always_comb begin
    case (funct3)
      rv_isa_pkg::br_blt, rv_isa_pkg::br_bge:   branch_alu = decode_pkg::alu_lts;
      rv_isa_pkg::br_bltu, rv_isa_pkg::br_bgeu: branch_alu = decode_pkg::alu_ltu;
      default:                                  branch_alu = decode_pkg::alu_xor;
    endcase
  end

  always_comb begin
    case (funct3)
      rv_isa_pkg::csr_rs, rv_isa_pkg::csr_rsi: csr_alu = decode_pkg::alu_or;
      rv_isa_pkg::csr_rc, rv_isa_pkg::csr_rci: csr_alu = decode_pkg::alu_and;
      default:                                 csr_alu = decode_pkg::alu_add;
    endcase
  end

  always_comb begin
    ctrl    = '0;
    ctrl.rd = held_inst.r.rd;
    sel     = '0;
    case (opcode)
      rv_isa_pkg::opc_lui: begin
        sel.sel_b = decode_pkg::sel_b_imm_u;
      end
      rv_isa_pkg::opc_auipc: begin
        ctrl.alu_src = 1'b1;
        sel.sel_b    = decode_pkg::sel_b_imm_u;
      end
      rv_isa_pkg::opc_jal: begin
        ctrl.alu_src = 1'b1;
        ctrl.goto    = decode_pkg::goto_pc_c;
        sel.sel_b    = decode_pkg::sel_b_four;
        sel.sel_c    = decode_pkg::sel_c_imm_j;
      end
      rv_isa_pkg::opc_jalr: begin
        ctrl.alu_src = 1'b1;
        ctrl.goto    = decode_pkg::goto_a_c;
        sel.sel_a    = decode_pkg::sel_a_rs1;
        sel.sel_b    = decode_pkg::sel_b_four;
        sel.sel_c    = decode_pkg::sel_c_imm_i;
      end
      rv_isa_pkg::opc_branch: begin
        ctrl.alu_funct = branch_alu;
        ctrl.rd        = 5'd0;
        // beq, bge and bgeu take the branch on a zero result
        ctrl.goto      = ((funct3[0] && funct3[2]) || funct3 == 3'b000) ?
                         decode_pkg::goto_z : decode_pkg::goto_nz;
        sel.sel_a      = decode_pkg::sel_a_rs1;
        sel.sel_b      = decode_pkg::sel_b_rs2;
        sel.sel_c      = decode_pkg::sel_c_imm_b;
      end
      rv_isa_pkg::opc_load: begin
        ctrl.ls   = {1'b1, !funct3[2], funct3[1:0]};
        sel.sel_a = decode_pkg::sel_a_rs1;
        sel.sel_b = decode_pkg::sel_b_imm_i;
      end
      rv_isa_pkg::opc_store: begin
        ctrl.ls   = {2'b01, funct3[1:0]};
        ctrl.rd   = 5'd0;
        sel.sel_a = decode_pkg::sel_a_rs1;
        sel.sel_b = decode_pkg::sel_b_imm_s;
        sel.sel_c = decode_pkg::sel_c_rs2;
      end
      rv_isa_pkg::opc_op_imm: begin
        ctrl.alu_funct = decode_pkg::alu_funct_t'(funct3);
        // srai is the only immediate op with a sign switch
        ctrl.alu_sw    = (funct3 == decode_pkg::alu_shr) && funct7[5];
        sel.sel_a      = decode_pkg::sel_a_rs1;
        sel.sel_b      = decode_pkg::sel_b_imm_i;
      end
      rv_isa_pkg::opc_op: begin
        ctrl.alu_funct = decode_pkg::alu_funct_t'(funct3);
        ctrl.alu_sw    = funct7[5];
        sel.sel_a      = decode_pkg::sel_a_rs1;
        sel.sel_b      = decode_pkg::sel_b_rs2;
      end
      rv_isa_pkg::opc_system: begin
        ctrl.alu_funct = csr_alu;
        // clear ops invert the mask before the and
        ctrl.alu_sw    = &funct3[1:0];
        ctrl.rd_src    = 1'b1;
        ctrl.goto      = (zicsr || ebreak) ? decode_pkg::goto_none : decode_pkg::goto_a;
        if (zicsr) begin
          ctrl.csrw = (funct3[1:0] == 2'b01) ? decode_pkg::csrw_val_b : decode_pkg::csrw_alu;
        end else if (ebreak) begin
          ctrl.csrw = decode_pkg::csrw_ebreak;
        end else begin
          // ecall saves pc to mepc, mret writes nothing
          ctrl.csrw = funct12[1] ? decode_pkg::csrw_none : decode_pkg::csrw_val_b;
        end
        sel.sel_a = decode_pkg::sel_a_csr;
        if (!zicsr) begin
          sel.sel_b = decode_pkg::sel_b_pc;
        end else if (funct3[2]) begin
          sel.sel_b = decode_pkg::sel_b_imm_z;
        end else begin
          sel.sel_b = decode_pkg::sel_b_rs2;
        end
        sel.sel_c = decode_pkg::sel_c_csr_addr;
      end
      default: begin
        ctrl.rd = 5'd0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/operand_select.sv
`default_nettype none

module operand_select (
  input  rv_isa_pkg::inst_t     held_inst,
  input  logic [31:0]           held_pc,
  input  decode_pkg::sel_t      sel,
  input  logic [31:0]           gpr_rdata1,
  input  logic [31:0]           gpr_rdata2,
  input  logic [31:0]           csr_rdata,
  output decode_pkg::operands_t ops
);

  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  logic [31:0] imm_z;
  logic [11:0] csr_addr;

  assign imm_i = {{20{held_inst.i.imm[11]}}, held_inst.i.imm};
  assign imm_s = {{20{held_inst.s.imm_11_5[6]}}, held_inst.s.imm_11_5, held_inst.s.imm_4_0};
  assign imm_b = {{20{held_inst.b.imm_12}}, held_inst.b.imm_11, held_inst.b.imm_10_5,
                  held_inst.b.imm_4_1, 1'b0};
  assign imm_u = {held_inst.u.imm_31_12, 12'h000};
  assign imm_j = {{12{held_inst.j.imm_20}}, held_inst.j.imm_19_12, held_inst.j.imm_11,
                  held_inst.j.imm_10_1, 1'b0};
  // zicsr immediate sits in the rs1 field
  assign imm_z = {27'd0, held_inst.i.rs1};

  // zicsr names its CSR, ecall/ebreak/mret target mepc
  assign csr_addr = (|held_inst.i.funct3) ? held_inst.i.imm : rv_isa_pkg::csr_mepc;

  assign ops.pc = held_pc;

  always_comb begin
    case (sel.sel_a)
      decode_pkg::sel_a_rs1: ops.val_a = gpr_rdata1;
      decode_pkg::sel_a_csr: ops.val_a = csr_rdata;
      default:               ops.val_a = 32'd0;
    endcase
  end

  always_comb begin
    case (sel.sel_b)
      decode_pkg::sel_b_imm_u: ops.val_b = imm_u;
      decode_pkg::sel_b_four:  ops.val_b = 32'd4;
      decode_pkg::sel_b_rs2:   ops.val_b = gpr_rdata2;
      decode_pkg::sel_b_imm_i: ops.val_b = imm_i;
      decode_pkg::sel_b_imm_s: ops.val_b = imm_s;
      decode_pkg::sel_b_imm_z: ops.val_b = imm_z;
      decode_pkg::sel_b_pc:    ops.val_b = held_pc;
      default:                 ops.val_b = 32'd0;
    endcase
  end

  always_comb begin
    case (sel.sel_c)
      decode_pkg::sel_c_imm_j:    ops.val_c = imm_j;
      decode_pkg::sel_c_imm_i:    ops.val_c = imm_i;
      decode_pkg::sel_c_imm_b:    ops.val_c = imm_b;
      decode_pkg::sel_c_rs2:      ops.val_c = gpr_rdata2;
      decode_pkg::sel_c_csr_addr: ops.val_c = {20'd0, csr_addr};
      default:                    ops.val_c = 32'd0;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/decode_unit.sv
`default_nettype none

module decode_unit #(
  parameter int num_gpr = 32
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  flush,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  logic [31:0]           in_pc,
  input  rv_isa_pkg::inst_t     in_inst,
  output logic                  out_valid,
  input  logic                  out_ready,
  output decode_pkg::ctrl_t     out_ctrl,
  output decode_pkg::operands_t out_ops,
  input  decode_pkg::gpr_wr_t   gpr_wr,
  input  decode_pkg::csr_wr_t   csr_wr
);

  rv_isa_pkg::inst_t held_inst;
  logic [31:0]       held_pc;
  decode_pkg::sel_t  sel;
  logic [4:0]        gpr_raddr1;
  logic [4:0]        gpr_raddr2;
  logic [31:0]       gpr_rdata1;
  logic [31:0]       gpr_rdata2;
  logic [11:0]       csr_raddr;
  logic [31:0]       csr_rdata;

  decode_ctrl u_ctrl (
    .clock      (clock),
    .reset      (reset),
    .flush      (flush),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_pc      (in_pc),
    .in_inst    (in_inst),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .held_inst  (held_inst),
    .held_pc    (held_pc),
    .ctrl       (out_ctrl),
    .sel        (sel),
    .gpr_raddr1 (gpr_raddr1),
    .gpr_raddr2 (gpr_raddr2),
    .csr_raddr  (csr_raddr)
  );

  operand_select u_operands (
    .held_inst  (held_inst),
    .held_pc    (held_pc),
    .sel        (sel),
    .gpr_rdata1 (gpr_rdata1),
    .gpr_rdata2 (gpr_rdata2),
    .csr_rdata  (csr_rdata),
    .ops        (out_ops)
  );

  gpr_file #(
    .num_gpr (num_gpr)
  ) u_gpr (
    .clock  (clock),
    .reset  (reset),
    .raddr1 (gpr_raddr1),
    .rdata1 (gpr_rdata1),
    .raddr2 (gpr_raddr2),
    .rdata2 (gpr_rdata2),
    .wr     (gpr_wr)
  );

  csr_file u_csr (
    .clock (clock),
    .reset (reset),
    .raddr (csr_raddr),
    .rdata (csr_rdata),
    .wr    (csr_wr)
  );

endmodule

`default_nettype wire

// File: test/decode_ref.svh
`ifndef decode_ref_svh
`define decode_ref_svh

`default_nettype none

typedef logic [31:0] gpr_set_t [32];
// model copies in the order mstatus, mtvec, mepc, mcause
typedef logic [31:0] csr_set_t [4];

function automatic logic [31:0] csr_read(input csr_set_t csr, input logic [11:0] addr);
  case (addr)
    rv_isa_pkg::csr_mstatus: return csr[0];
    rv_isa_pkg::csr_mtvec:   return csr[1];
    rv_isa_pkg::csr_mepc:    return csr[2];
    rv_isa_pkg::csr_mcause:  return csr[3];
    default:                 return 32'd0;
  endcase
endfunction

// random word turned into a legal encoding of the given opcode
function automatic logic [31:0] form_inst(input logic [31:0] raw,
                                          input rv_isa_pkg::opcode_t opc,
                                          input logic [2:0] funct3);
  rv_isa_pkg::inst_t inst;
  inst = raw;
  inst.r.quadrant = 2'b11;
  inst.r.opcode   = opc;
  inst.r.funct3   = funct3;
  return inst;
endfunction

function automatic logic [31:0] with_funct7(input logic [31:0] word, input logic [6:0] funct7);
  rv_isa_pkg::inst_t inst;
  inst = word;
  inst.r.funct7 = funct7;
  return inst;
endfunction

function automatic logic [31:0] with_csr(input logic [31:0] word, input logic [11:0] addr);
  rv_isa_pkg::inst_t inst;
  inst = word;
  inst.i.imm = addr;
  return inst;
endfunction

function automatic void decode_ref(input logic [31:0] pc,
                                   input logic [31:0] word,
                                   input gpr_set_t gpr,
                                   input csr_set_t csr,
                                   output decode_pkg::ctrl_t ctrl,
                                   output decode_pkg::operands_t ops);
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [2:0]  f3;
  logic [11:0] f12;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  rd    = word[11:7];
  rs1   = word[19:15];
  rs2   = word[24:20];
  f3    = word[14:12];
  f12   = word[31:20];
  imm_i = {{20{word[31]}}, word[31:20]};
  imm_s = {{20{word[31]}}, word[31:25], word[11:7]};
  imm_b = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
  imm_u = {word[31:12], 12'h000};
  imm_j = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
  ctrl    = '0;
  ops     = '0;
  ops.pc  = pc;
  ctrl.rd = rd;
  case (rv_isa_pkg::opcode_t'(word[6:2]))
    rv_isa_pkg::opc_lui: begin
      ops.val_b = imm_u;
    end
    rv_isa_pkg::opc_auipc: begin
      ctrl.alu_src = 1'b1;
      ops.val_b    = imm_u;
    end
    rv_isa_pkg::opc_jal: begin
      ctrl.alu_src = 1'b1;
      ctrl.goto    = decode_pkg::goto_pc_c;
      ops.val_b    = 32'd4;
      ops.val_c    = imm_j;
    end
    rv_isa_pkg::opc_jalr: begin
      ctrl.alu_src = 1'b1;
      ctrl.goto    = decode_pkg::goto_a_c;
      ops.val_a    = gpr[rs1];
      ops.val_b    = 32'd4;
      ops.val_c    = imm_i;
    end
    rv_isa_pkg::opc_branch: begin
      ctrl.rd = 5'd0;
      if (!f3[2]) begin
        ctrl.alu_funct = decode_pkg::alu_xor;
      end else if (f3[1]) begin
        ctrl.alu_funct = decode_pkg::alu_ltu;
      end else begin
        ctrl.alu_funct = decode_pkg::alu_lts;
      end
      // beq, bge, bgeu are taken when the compare gives zero
      ctrl.goto = (f3[0] == f3[2]) ? decode_pkg::goto_z : decode_pkg::goto_nz;
      ops.val_a = gpr[rs1];
      ops.val_b = gpr[rs2];
      ops.val_c = imm_b;
    end
    rv_isa_pkg::opc_load: begin
      ctrl.ls   = {1'b1, ~f3[2], f3[1:0]};
      ops.val_a = gpr[rs1];
      ops.val_b = imm_i;
    end
    rv_isa_pkg::opc_store: begin
      ctrl.ls   = {1'b0, 1'b1, f3[1:0]};
      ctrl.rd   = 5'd0;
      ops.val_a = gpr[rs1];
      ops.val_b = imm_s;
      ops.val_c = gpr[rs2];
    end
    rv_isa_pkg::opc_op_imm, rv_isa_pkg::opc_op: begin
      ctrl.alu_funct = decode_pkg::alu_funct_t'(f3);
      ops.val_a      = gpr[rs1];
      if (word[5]) begin
        ctrl.alu_sw = word[30];
        ops.val_b   = gpr[rs2];
      end else begin
        ctrl.alu_sw = (f3 == 3'd5) && word[30];
        ops.val_b   = imm_i;
      end
    end
    rv_isa_pkg::opc_system: begin
      ctrl.rd_src = 1'b1;
      if (f3 != 3'd0) begin
        ops.val_a = csr_read(csr, f12);
        // immediate forms carry the value in the rs1 field
        ops.val_b = f3[2] ? {27'd0, rs1} : gpr[rs1];
        ops.val_c = {20'd0, f12};
        if (f3[1:0] == 2'b10) begin
          ctrl.alu_funct = decode_pkg::alu_or;
        end else if (f3[1:0] == 2'b11) begin
          ctrl.alu_funct = decode_pkg::alu_and;
          ctrl.alu_sw    = 1'b1;
        end
        ctrl.csrw = (f3[1:0] == 2'b01) ? decode_pkg::csrw_val_b : decode_pkg::csrw_alu;
      end else begin
        ops.val_b = pc;
        ops.val_c = {20'd0, rv_isa_pkg::csr_mepc};
        if (f12 == 12'h302) begin
          // mret
          ops.val_a = csr_read(csr, rv_isa_pkg::csr_mepc);
          ctrl.goto = decode_pkg::goto_a;
        end else if (f12 == 12'h001) begin
          ops.val_a = csr_read(csr, rv_isa_pkg::csr_mtvec);
          ctrl.csrw = decode_pkg::csrw_ebreak;
        end else begin
          // ecall
          ops.val_a = csr_read(csr, rv_isa_pkg::csr_mtvec);
          ctrl.goto = decode_pkg::goto_a;
          ctrl.csrw = decode_pkg::csrw_val_b;
        end
      end
    end
    default: begin
      ctrl.rd = 5'd0;
    end
  endcase
endfunction

`default_nettype wire

`endif

// File: test/decode_unit_tb.sv
`include "decode_ref.svh"

`default_nettype none

module decode_unit_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int wait_limit = 200;
  localparam int cmp_w = $bits(decode_pkg::ctrl_t) + $bits(decode_pkg::operands_t);
  localparam logic [4:0][2:0] load_f3 = {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
  localparam logic [2:0][2:0] store_f3 = {3'd0, 3'd1, 3'd2};
  localparam logic [5:0][2:0] branch_f3 = {3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
  localparam logic [5:0][2:0] csr_f3 = {3'd1, 3'd2, 3'd3, 3'd5, 3'd6, 3'd7};
  // the last two are not implemented and read zero
  localparam logic [5:0][11:0] csr_addrs = {rv_isa_pkg::csr_mstatus, rv_isa_pkg::csr_mtvec,
                                            rv_isa_pkg::csr_mepc, rv_isa_pkg::csr_mcause,
                                            12'h344, 12'hc00};

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
  } issued_t;

  logic                  clock;
  logic                  reset;
  logic                  flush;
  logic                  in_valid;
  logic                  in_ready;
  logic [31:0]           in_pc;
  rv_isa_pkg::inst_t     in_inst;
  logic                  out_valid;
  logic                  out_ready;
  decode_pkg::ctrl_t     out_ctrl;
  decode_pkg::operands_t out_ops;
  decode_pkg::gpr_wr_t   gpr_wr;
  decode_pkg::csr_wr_t   csr_wr;

  gpr_set_t              gpr_model;
  csr_set_t              csr_model;
  issued_t               pending[$];
  decode_pkg::ctrl_t     ctrl_exp;
  decode_pkg::operands_t ops_exp;
  string                 test_name;
  logic [1:0]            ready_mode;
  logic [31:0]           next_pc;

  decode_unit #(
    .num_gpr (32)
  ) i_dut (
    .clock     (clock),
    .reset     (reset),
    .flush     (flush),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_pc     (in_pc),
    .in_inst   (in_inst),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_ctrl  (out_ctrl),
    .out_ops   (out_ops),
    .gpr_wr    (gpr_wr),
    .csr_wr    (csr_wr)
  );

  always #2 clock = ~clock;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic compare(input string name, input logic [cmp_w-1:0] expected,
                         input logic [cmp_w-1:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("ERR %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  // 0 holds out_ready low, 1 high, 2 random
  always @(negedge clock) begin
    case (ready_mode)
      2'd0:    out_ready = 1'b0;
      2'd1:    out_ready = 1'b1;
      default: out_ready = $urandom % 2;
    endcase
  end

  // every edge checks the handshake, and the output whenever it is offered
  always @(posedge clock) begin
    if (!reset) begin
      compare({test_name, " out_valid"}, cmp_w'(pending.size() != 0 && !flush),
              cmp_w'(out_valid));
      compare({test_name, " in_ready"}, cmp_w'(pending.size() == 0 || out_ready || flush),
              cmp_w'(in_ready));
      if (out_valid) begin
        decode_ref(pending[0].pc, pending[0].inst, gpr_model, csr_model, ctrl_exp, ops_exp);
        compare(test_name, {ctrl_exp, ops_exp}, {out_ctrl, out_ops});
        if (out_ready) begin
          void'(pending.pop_front());
        end
      end else if (flush && pending.size() != 0) begin
        // the held item is dropped and must never come out
        void'(pending.pop_front());
      end
    end
  end

  function automatic logic [31:0] random_inst(input int kind);
    logic [31:0] raw;
    logic [31:0] word;
    logic [2:0]  f3;
    logic [6:0]  f7;
    raw  = $urandom;
    f3   = raw[14:12];
    f7   = raw[30] ? 7'h20 : 7'h00;
    word = raw;
    case (kind)
      0: word = with_funct7(form_inst(raw, rv_isa_pkg::opc_op, f3),
                            (f3 == 3'd0 || f3 == 3'd5) ? f7 : 7'h00);
      1: begin
        word = form_inst(raw, rv_isa_pkg::opc_op_imm, f3);
        if (f3 == 3'd1 || f3 == 3'd5) begin
          word = with_funct7(word, (f3 == 3'd5) ? f7 : 7'h00);
        end
      end
      2: word = form_inst(raw, rv_isa_pkg::opc_load, load_f3[$urandom % 5]);
      3: word = form_inst(raw, rv_isa_pkg::opc_store, store_f3[$urandom % 3]);
      4: word = form_inst(raw, rv_isa_pkg::opc_branch, branch_f3[$urandom % 6]);
      5: word = form_inst(raw, rv_isa_pkg::opc_jal, f3);
      6: word = form_inst(raw, rv_isa_pkg::opc_jalr, 3'd0);
      7: word = form_inst(raw, rv_isa_pkg::opc_lui, f3);
      8: word = form_inst(raw, rv_isa_pkg::opc_auipc, f3);
      9: word = with_csr(form_inst(raw, rv_isa_pkg::opc_system, csr_f3[$urandom % 6]),
                         csr_addrs[$urandom % 6]);
      10: word = 32'h0000_0073;
      11: word = 32'h0010_0073;
      default: word = 32'h3020_0073;
    endcase
    return word;
  endfunction

  task automatic set_ready(input logic [1:0] mode);
    ready_mode = mode;
    @(negedge clock);
    @(negedge clock);
  endtask

  // offers one instruction and returns on the falling edge after it was taken
  task automatic issue(input logic [31:0] word);
    int cycles;
    in_valid = 1'b1;
    in_pc    = next_pc;
    in_inst  = word;
    cycles   = 0;
    do begin
      if (cycles == wait_limit) begin
        abort_run($sformatf("%s: input was never accepted", test_name));
      end
      @(posedge clock);
      cycles++;
    end while (!in_ready);
    @(negedge clock);
    pending.push_back({next_pc, word});
    in_valid = 1'b0;
    next_pc  = next_pc + 32'd4;
  endtask

  task automatic drain();
    int cycles;
    cycles = 0;
    while (pending.size() != 0) begin
      if (cycles == wait_limit) begin
        abort_run($sformatf("%s: decoded output never arrived", test_name));
      end
      @(negedge clock);
      cycles++;
    end
  endtask

  task automatic run_kinds(input int first, input int last, input int count);
    for (int n = 0; n < count; n++) begin
      issue(random_inst(first + $urandom % (last - first + 1)));
    end
    drain();
  endtask

  task automatic load_registers();
    gpr_model[0] = 32'd0;
    for (int r = 1; r < 32; r++) begin
      gpr_model[r] = $urandom;
      gpr_wr.en    = 1'b1;
      gpr_wr.addr  = 5'(r);
      gpr_wr.data  = gpr_model[r];
      csr_wr.en    = 1'b0;
      if (r <= 4) begin
        csr_model[r-1] = $urandom;
        csr_wr.en      = 1'b1;
        csr_wr.addr    = csr_addrs[6-r];
        csr_wr.data    = csr_model[r-1];
      end
      @(negedge clock);
    end
    gpr_wr = '0;
    csr_wr = '0;
  endtask

  initial begin
    void'($urandom(32'hfefbe483));
    clock      = 1'b0;
    reset      = 1'b1;
    flush      = 1'b0;
    in_valid   = 1'b0;
    in_pc      = 32'd0;
    in_inst    = 32'd0;
    out_ready  = 1'b0;
    gpr_wr     = '0;
    csr_wr     = '0;
    ready_mode = 2'd1;
    next_pc    = 32'h0000_1000;
    test_name  = "reset";
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    load_registers();

    test_name = "alu ops";
    run_kinds(0, 1, 60);
    test_name = "loads and stores";
    run_kinds(2, 3, 60);
    test_name = "branches and jumps";
    run_kinds(4, 8, 80);
    test_name = "system";
    run_kinds(9, 12, 60);

    test_name = "back-pressure";
    set_ready(2'd2);
    run_kinds(0, 12, 150);
    set_ready(2'd1);

    // flush with a new instruction taken in the same cycle
    test_name = "flush";
    set_ready(2'd0);
    issue(random_inst(0));
    @(negedge clock);
    flush = 1'b1;
    issue(random_inst(4));
    flush = 1'b0;
    set_ready(2'd1);
    drain();

    // flush with nothing offered, then a fresh instruction
    set_ready(2'd0);
    issue(random_inst(9));
    flush = 1'b1;
    @(negedge clock);
    flush = 1'b0;
    set_ready(2'd1);
    issue(random_inst(5));
    drain();

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+test
verilog/rv_isa_pkg.sv
verilog/decode_pkg.sv
verilog/gpr_file.sv
verilog/csr_file.sv
verilog/decode_ctrl.sv
verilog/operand_select.sv
verilog/decode_unit.sv
test/decode_unit_tb.sv

// File: Bender.yml
package:
  name: decode_unit

sources:
  - files:
      - verilog/rv_isa_pkg.sv
      - verilog/decode_pkg.sv
      - verilog/gpr_file.sv
      - verilog/csr_file.sv
      - verilog/decode_ctrl.sv
      - verilog/operand_select.sv
      - verilog/decode_unit.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/decode_unit_tb.sv
